/* bench/s16b_main_bus_chk.sv */
// Bus glue checker: assertions on selects, ROM map, video registers and CPU read data
`timescale 1ns/1ps

module s16b_main_bus_chk (
    input logic                            clk,
    input logic                            rst,
    input logic [s16b_pkg::byte_w-1:0]     game_id,
    input logic [s16b_pkg::addr_w:1]       addr,
    input logic                            as_n,
    input logic                            rnw,
    input logic                            uds_n,
    input logic                            lds_n,
    input logic [s16b_pkg::data_w-1:0]     cpu_dout,
    input logic [s16b_pkg::region_w-1:0]   active,
    input logic [s16b_pkg::data_w-1:0]     ram_data,
    input logic [s16b_pkg::data_w-1:0]     rom_data,
    input logic [s16b_pkg::data_w-1:0]     char_dout,
    input logic [s16b_pkg::data_w-1:0]     pal_dout,
    input logic [s16b_pkg::data_w-1:0]     obj_dout,
    input logic [s16b_pkg::byte_w-1:0]     joystick1,
    input logic [s16b_pkg::byte_w-1:0]     joystick2,
    input logic [s16b_pkg::byte_w-1:0]     joystick3,
    input logic [3:0]                      start_button,
    input logic [3:0]                      coin_input,
    input logic                            service,
    input logic                            dip_test,
    input logic [s16b_pkg::byte_w-1:0]     dipsw_a,
    input logic [s16b_pkg::byte_w-1:0]     dipsw_b,
    input logic                            rom_cs,
    input logic                            ram_cs,
    input logic                            vram_cs,
    input logic                            char_cs,
    input logic                            pal_cs,
    input logic                            objram_cs,
    input logic                            io_cs,
    input logic                            tbank_cs,
    input logic [s16b_pkg::byte_w-1:0]     cab_dout,
    input logic [s16b_pkg::rom_addr_w:1]   rom_addr,
    input logic [s16b_pkg::data_w-1:0]     cpu_din,
    input logic                            flip,
    input logic                            video_en,
    input logic [5:0]                      tile_bank
);
    import s16b_pkg::*;

    int unsigned reset_fails = 0;
    int unsigned sel_fails = 0;
    int unsigned map_fails = 0;
    int unsigned video_fails = 0;
    int unsigned bank_fails = 0;
    int unsigned read_fails = 0;
    int unsigned rom_lat_fails = 0;
    int unsigned cab_fails = 0;
    int unsigned fail_cnt;      // Total, read by the testbench

    logic                  ds_on;
    logic [7:0]            exp_sel;
    logic [7:0]            got_sel;
    logic [1:0]            rom_idx;
    logic [rom_addr_w:1]   exp_rom;
    logic                  vid_wr;
    logic                  bank_wr;
    logic [1:0]            exp_vid;
    logic [5:0]            exp_bank;
    logic [data_w-1:0]     exp_rd;
    logic                  bullet;
    logic                  passsht;
    logic [byte_w-1:0]     exp_cab;
    logic                  rom_rd_go;
    logic                  cab_rd_go;

    // Cabinet wiring of one joystick, Bullet swaps the nibbles
    function automatic logic [7:0] wire_joy(input logic [7:0] j, input logic swap);
        logic [7:0] w;
        w = {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
        return swap ? {w[3:0], w[7:4]} : w;
    endfunction

    assign fail_cnt = reset_fails + sel_fails + map_fails + video_fails + bank_fails +
                      read_fails + rom_lat_fails + cab_fails;

    assign got_sel = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, tbank_cs};

    always_comb begin
        ds_on   = !uds_n || !lds_n;
        exp_sel = 8'd0;
        if (!as_n) begin
            exp_sel[7] = rnw && (active[0] || active[1] || active[2]);
            exp_sel[6] = active[reg_ram] && ds_on;
            exp_sel[5] = active[reg_vram] && !addr[16] && ds_on;
            exp_sel[4] = active[reg_vram] && addr[16];
            exp_sel[3] = active[reg_pal];
            exp_sel[2] = active[reg_oram];
            exp_sel[1] = active[reg_io];
            exp_sel[0] = active[reg_rom_hi] && !rnw;    // Tile bank latch
        end
    end

    // ROM index is 0 unless exactly region 1 or 2 is hit
    always_comb begin
        rom_idx = 2'd0;
        if (active[2:0] == 3'b010) begin
            rom_idx = 2'd1;
        end else if (active[2:0] == 3'b100) begin
            rom_idx = 2'd2;
        end
        if (game_id[7:4] inside {4'd2, 4'd3}) begin
            exp_rom = addr[18:1];
        end else if (game_id inside {game_5358_large_a, game_5358_large_b}) begin
            exp_rom = {rom_idx, addr[16:1]};
        end else if (game_id[7:3] inside {5'd2, 5'd3}) begin
            exp_rom = {1'b0, rom_idx, addr[15:1]};
        end else if (game_id[7:3] == 5'd1) begin
            exp_rom = {1'b0, addr[17:1]};
        end else begin
            exp_rom = {rom_idx[0], addr[17:1]};
        end
    end

    assign vid_wr  = io_cs && addr[13:12] == 2'd0 && !rnw && !lds_n;
    assign bank_wr = tbank_cs && !rnw && !lds_n;

    // Register contents expected after this edge
    always_comb begin
        exp_vid  = vid_wr ? cpu_dout[6:5] : {flip, video_en};
        exp_bank = tile_bank;
        if (bank_wr && addr[1]) begin
            exp_bank[5:3] = cpu_dout[2:0];
        end
        if (bank_wr && !addr[1]) begin
            exp_bank[2:0] = cpu_dout[2:0];
        end
    end

    always_comb begin
        if (ram_cs || vram_cs) begin
            exp_rd = ram_data;
        end else if (rom_cs) begin
            exp_rd = rom_data;
        end else if (char_cs) begin
            exp_rd = char_dout;
        end else if (pal_cs) begin
            exp_rd = pal_dout;
        end else if (objram_cs) begin
            exp_rd = obj_dout;
        end else if (io_cs) begin
            exp_rd = {8'hff, cab_dout};
        end else begin
            exp_rd = cpu_din;       // Nothing selected, bus keeps its value
        end
    end

    always_comb begin
        bullet  = game_id == game_bullet;
        passsht = game_id inside {game_passsht, game_passsht2, game_passsht3};
        exp_cab = 8'hff;
        if (addr[13:12] == 2'd2) begin
            exp_cab = addr[1] ? dipsw_a : dipsw_b;
        end else if (addr[13:12] == 2'd1) begin
            case (addr[2:1])
                2'd0: begin
                    exp_cab = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};
                    if (bullet) begin
                        exp_cab[7:6] = {coin_input[2], start_button[2]};
                    end
                    if (passsht) begin
                        exp_cab[7:6] = start_button[3:2];
                    end
                end
                2'd1: exp_cab = wire_joy(joystick1, bullet);
                2'd2: exp_cab = bullet ? wire_joy(joystick3, 1'b1) : 8'hff;
                2'd3: exp_cab = wire_joy(joystick2, bullet);
            endcase
        end
    end

    // First cycle of a plain ROM read and of a cabinet read
    assign rom_rd_go = !as_n && rnw && active[2:0] != 3'd0 && active[7:3] == 5'd0;
    assign cab_rd_go = !as_n && rnw && active == 8'h80 &&
                       (addr[13:12] == 2'd1 || addr[13:12] == 2'd2);

    a_reset: assert property (@(posedge clk) rst |-> got_sel == 8'd0 && !flip && video_en &&
                              tile_bank == 6'd0 && cab_dout == 8'hff && cpu_din == bus_idle)
        else begin
            reset_fails++;
            $error("Reset values wrong");
        end

    a_sel: assert property (@(posedge clk) disable iff (rst) got_sel == $past(exp_sel))
        else begin
            sel_fails++;
            $error("Chip selects %b do not match the region decode", got_sel);
        end

    a_map: assert property (@(posedge clk) rom_addr == exp_rom)
        else begin
            map_fails++;
            $error("rom_addr %h, expected %h for game %h", rom_addr, exp_rom, game_id);
        end

    a_video: assert property (@(posedge clk) disable iff (rst)
                              {flip, video_en} == $past(exp_vid))
        else begin
            video_fails++;
            $error("flip or video_en wrong after an I/O write");
        end

    a_bank: assert property (@(posedge clk) disable iff (rst) tile_bank == $past(exp_bank))
        else begin
            bank_fails++;
            $error("tile_bank %h wrong", tile_bank);
        end

    a_read: assert property (@(posedge clk) disable iff (rst) cpu_din == $past(exp_rd))
        else begin
            read_fails++;
            $error("cpu_din %h does not follow the read priority", cpu_din);
        end

    // Memory data two cycles after the first strobe sample
    a_rom_lat: assert property (@(posedge clk) disable iff (rst)
                                $past(as_n, 3) && $past(rom_rd_go, 2) |->
                                cpu_din == $past(rom_data, 2))
        else begin
            rom_lat_fails++;
            $error("ROM read data late or wrong, cpu_din %h", cpu_din);
        end

    a_cab: assert property (@(posedge clk) disable iff (rst)
                            $past(as_n, 4) && $past(cab_rd_go, 3) |->
                            cpu_din == {8'hff, $past(exp_cab, 3)})
        else begin
            cab_fails++;
            $error("Cabinet byte wrong, cpu_din %h", cpu_din);
        end

endmodule

bind s16b_main_bus s16b_main_bus_chk chk_i (.*);

/* bench/s16b_main_bus_tb.sv */
// Testbench for the System 16B main bus glue with stimulus, watchdog and test reports
`timescale 1ns/1ps

module s16b_main_bus_tb;
    import s16b_pkg::*;

    localparam int clk_period   = 40;
    localparam int limit_cycles = 2000;  // About 85 accesses of six cycles plus margin

    logic                  clk;
    logic                  rst;
    logic [byte_w-1:0]     game_id;
    logic [addr_w:1]       addr;
    logic                  as_n;
    logic                  rnw;
    logic                  uds_n;
    logic                  lds_n;
    logic [data_w-1:0]     cpu_dout;
    logic [region_w-1:0]   active;
    logic [data_w-1:0]     ram_data;
    logic [data_w-1:0]     rom_data;
    logic [data_w-1:0]     char_dout;
    logic [data_w-1:0]     pal_dout;
    logic [data_w-1:0]     obj_dout;
    logic [byte_w-1:0]     joystick1;
    logic [byte_w-1:0]     joystick2;
    logic [byte_w-1:0]     joystick3;
    logic [3:0]            start_button;
    logic [3:0]            coin_input;
    logic                  service;
    logic                  dip_test;
    logic [byte_w-1:0]     dipsw_a;
    logic [byte_w-1:0]     dipsw_b;
    logic                  rom_cs;
    logic                  ram_cs;
    logic                  vram_cs;
    logic                  char_cs;
    logic                  pal_cs;
    logic                  objram_cs;
    logic [rom_addr_w:1]   rom_addr;
    logic [data_w-1:0]     cpu_din;
    logic                  flip;
    logic                  video_en;
    logic [5:0]            tile_bank;

    logic [31:0]           rng;
    int unsigned           tests_run;
    int unsigned           tests_failed;
    int unsigned           fails_seen;

    s16b_main_bus dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the tests did not finish", limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // New data and player inputs held for the whole access
    task automatic scramble_inputs();
        rng = xorshift32(rng);
        ram_data  <= rng[15:0];
        rom_data  <= rng[31:16];
        rng = xorshift32(rng);
        char_dout <= rng[15:0];
        pal_dout  <= rng[31:16];
        rng = xorshift32(rng);
        obj_dout  <= rng[15:0];
        cpu_dout  <= rng[31:16];
        rng = xorshift32(rng);
        joystick1 <= rng[7:0];
        joystick2 <= rng[15:8];
        joystick3 <= rng[23:16];
        start_button <= rng[27:24];
        coin_input   <= rng[31:28];
        rng = xorshift32(rng);
        service  <= rng[0];
        dip_test <= rng[1];
        dipsw_a  <= rng[9:2];
        dipsw_b  <= rng[17:10];
    endtask

    // Starts right after a rising edge and holds as_n low for four cycles and high for two
    task automatic bus_access(input logic [region_w-1:0] region, input logic [addr_w:1] a,
                              input logic rd, input logic [1:0] ds_n);
        scramble_inputs();
        active <= region;
        addr   <= a;
        rnw    <= rd;
        uds_n  <= ds_n[1];
        lds_n  <= ds_n[0];
        as_n   <= 1'b0;
        repeat (4) @(posedge clk);
        as_n <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        int unsigned now_fails;
        @(negedge clk);         // Assertions of the last edge have settled
        now_fails = dut_i.chk_i.fail_cnt;
        tests_run++;
        if (now_fails != fails_seen) begin
            tests_failed++;
            $display("Fail at %0d ns: %s, %0d assertion failures", $time, name,
                     now_fails - fails_seen);
        end else begin
            $display("Test %s finished without assertion failures", name);
        end
        fails_seen = now_fails;
        @(posedge clk);
    endtask

    task automatic walk_regions();
        logic [addr_w:1] a;
        for (int r = 0; r < region_w; r++) begin
            for (int rw = 0; rw < 2; rw++) begin
                rng = xorshift32(rng);
                a = rng[22:0];
                bus_access(8'd1 << r, a, rw[0], rng[24:23]);
            end
        end
        rng = xorshift32(rng);
        a = rng[22:0];
        bus_access(8'd1 << reg_ram, a, 1'b1, 2'b11);   // No data strobe
        a[16] = 1'b0;
        bus_access(8'd1 << reg_vram, a, 1'b1, 2'b10);
        a[16] = 1'b1;
        bus_access(8'd1 << reg_vram, a, 1'b1, 2'b11);
    endtask

    task automatic sweep_rom_map();
        logic [7:0]      games [9] = '{8'h20, 8'h35, game_5358_large_a, game_5358_large_b,
                                       8'h12, 8'h1c, 8'h08, 8'h00, 8'h45};
        logic [addr_w:1] a;
        for (int g = 0; g < 9; g++) begin
            game_id <= games[g];
            for (int r = 0; r < 3; r++) begin
                rng = xorshift32(rng);
                a = rng[22:0];
                bus_access(8'd1 << r, a, 1'b1, 2'b00);
            end
        end
    endtask

    task automatic write_video_regs();
        logic [addr_w:1] a;
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            a = rng[22:0];
            a[13:12] = 2'd0;
            bus_access(8'd1 << reg_io, a, 1'b0, {1'b0, i == 2});  // Last one without lds_n
        end
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            a = rng[22:0];
            a[1] = i[0];
            bus_access(8'd1 << reg_rom_hi, a, 1'b0, 2'b00);
        end
    endtask

    // Random region mixes exercise the read priority
    task automatic read_memories();
        logic [addr_w:1] a;
        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            a = rng[22:0];
            bus_access(rng[31:24], a, 1'b1, 2'b00);
        end
    endtask

    task automatic read_cabinet();
        logic [7:0]      games [3] = '{8'h00, game_bullet, game_passsht2};
        logic [addr_w:1] a;
        for (int g = 0; g < 3; g++) begin
            game_id <= games[g];
            repeat (2) @(posedge clk);
            for (int k = 0; k < 6; k++) begin
                rng = xorshift32(rng);
                a = rng[22:0];
                a[13:12] = (k < 4) ? 2'd1 : 2'd2;
                a[2:1] = k[1:0];        // Offsets 0 to 3 and then both DIP banks
                bus_access(8'd1 << reg_io, a, 1'b1, 2'b00);
            end
        end
    endtask

    initial begin
        rng = 32'hf8627d0b;
        tests_run = 0;
        tests_failed = 0;
        fails_seen = 0;
        rst <= 1'b1;
        game_id <= 8'h00;
        addr <= '0;
        as_n <= 1'b1;
        rnw <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        active <= '0;
        scramble_inputs();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        report_test("reset values");
        walk_regions();
        report_test("select decode");
        sweep_rom_map();
        report_test("ROM mapping");
        write_video_regs();
        report_test("register writes");
        read_memories();
        report_test("memory reads");
        read_cabinet();
        report_test("cabinet reads");
        @(negedge clk);
        $display("Tests run %0d, tests failing %0d, assertion failures %0d",
                 tests_run, tests_failed, dut_i.chk_i.fail_cnt);
        if (tests_failed == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hw/s16b_cab_inputs.sv */
// Cabinet input byte built from joysticks, buttons and DIP switches for I/O reads
`timescale 1ns/1ps

module s16b_cab_inputs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        io_cs,
    input  logic [s16b_pkg::addr_w:1]   addr,
    input  logic [s16b_pkg::byte_w-1:0] game_id,
    input  logic [s16b_pkg::byte_w-1:0] joystick1,
    input  logic [s16b_pkg::byte_w-1:0] joystick2,
    input  logic [s16b_pkg::byte_w-1:0] joystick3,
    input  logic [3:0]                  start_button,
    input  logic [3:0]                  coin_input,
    input  logic                        service,
    input  logic                        dip_test,
    input  logic [s16b_pkg::byte_w-1:0] dipsw_a,
    input  logic [s16b_pkg::byte_w-1:0] dipsw_b,
    output logic [s16b_pkg::byte_w-1:0] cab_dout
);
    import s16b_pkg::*;

    logic              is_bullet;
    logic              is_passsht;
    logic [byte_w-1:0] joy1_s;
    logic [byte_w-1:0] joy2_s;
    logic [byte_w-1:0] joy3_s;
    logic [byte_w-1:0] sys_byte;
    logic [byte_w-1:0] cab_nx;

    // Board wiring order of the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    function automatic logic [7:0] nib_swap(input logic [7:0] val);
        nib_swap = {val[3:0], val[7:4]};
    endfunction

    assign is_bullet = game_id == game_bullet;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            is_passsht <= 1'b0;
        end else begin
            is_passsht <= game_id == game_passsht || game_id == game_passsht2 ||
                          game_id == game_passsht3;
        end
    end

    assign joy1_s = is_bullet ? nib_swap(sort_joy(joystick1)) : sort_joy(joystick1);
    assign joy2_s = is_bullet ? nib_swap(sort_joy(joystick2)) : sort_joy(joystick2);
    assign joy3_s = nib_swap(sort_joy(joystick3));     // Only wired on Bullet

    always_comb begin
        sys_byte = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};
        if (is_bullet) begin
            sys_byte[7] = coin_input[2];    // Third player
            sys_byte[6] = start_button[2];
        end
        if (is_passsht) begin
            sys_byte[7:6] = start_button[3:2];  // Four player cabinet
        end
    end

    always_comb begin
        cab_nx = 8'hff;
        if (io_cs && addr[13:12] == 2'd1) begin
            case (addr[2:1])
                2'd0: cab_nx = sys_byte;
                2'd1: cab_nx = joy1_s;
                2'd2: cab_nx = is_bullet ? joy3_s : 8'hff;
                2'd3: cab_nx = joy2_s;
            endcase
        end else if (io_cs && addr[13:12] == 2'd2) begin
            cab_nx = addr[1] ? dipsw_a : dipsw_b;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
        end else begin
            cab_dout <= cab_nx;
        end
    end

endmodule

/* hw/s16b_main_bus.sv */
// Main CPU bus glue for a System 16B board: selects, ROM banking, video regs, read path
`timescale 1ns/1ps

module s16b_main_bus (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [s16b_pkg::byte_w-1:0]     game_id,
    input  logic [s16b_pkg::addr_w:1]       addr,
    input  logic                            as_n,
    input  logic                            rnw,
    input  logic                            uds_n,
    input  logic                            lds_n,
    input  logic [s16b_pkg::data_w-1:0]     cpu_dout,
    input  logic [s16b_pkg::region_w-1:0]   active,
    input  logic [s16b_pkg::data_w-1:0]     ram_data,
    input  logic [s16b_pkg::data_w-1:0]     rom_data,
    input  logic [s16b_pkg::data_w-1:0]     char_dout,
    input  logic [s16b_pkg::data_w-1:0]     pal_dout,
    input  logic [s16b_pkg::data_w-1:0]     obj_dout,
    input  logic [s16b_pkg::byte_w-1:0]     joystick1,
    input  logic [s16b_pkg::byte_w-1:0]     joystick2,
    input  logic [s16b_pkg::byte_w-1:0]     joystick3,
    input  logic [3:0]                      start_button,
    input  logic [3:0]                      coin_input,
    input  logic                            service,
    input  logic                            dip_test,
    input  logic [s16b_pkg::byte_w-1:0]     dipsw_a,
    input  logic [s16b_pkg::byte_w-1:0]     dipsw_b,
    output logic                            rom_cs,
    output logic                            ram_cs,
    output logic                            vram_cs,
    output logic                            char_cs,
    output logic                            pal_cs,
    output logic                            objram_cs,
    output logic [s16b_pkg::rom_addr_w:1]   rom_addr,
    output logic [s16b_pkg::data_w-1:0]     cpu_din,
    output logic                            flip,
    output logic                            video_en,
    output logic [5:0]                      tile_bank
);
    import s16b_pkg::*;

    logic              io_cs;
    logic              tbank_cs;
    logic [byte_w-1:0] cab_dout;

    s16b_region_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .as_n      (as_n),
        .rnw       (rnw),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .addr16    (addr[16]),
        .active    (active),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs)
    );

    s16b_rom_bank u_rom_bank (
        .game_id  (game_id),
        .addr     (addr),
        .active   (active[reg_rom_hi:0]),   // ROM part of the region vector
        .rom_addr (rom_addr)
    );

    s16b_video_regs u_video_regs (
        .clk       (clk),
        .rst       (rst),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs),
        .rnw       (rnw),
        .lds_n     (lds_n),
        .addr      (addr),
        .cpu_dout  (cpu_dout),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank)
    );

    s16b_cab_inputs u_cab_inputs (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .addr         (addr),
        .game_id      (game_id),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .joystick3    (joystick3),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout)
    );

    s16b_read_mux u_read_mux (
        .clk       (clk),
        .rst       (rst),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

endmodule

/* hw/s16b_pkg.sv */
// System 16B main bus glue constants: region numbers, game identifiers and bus widths
package s16b_pkg;

    // Bus widths
    localparam int addr_w     = 23; // Word address, bits 23 to 1
    localparam int rom_addr_w = 18;
    localparam int data_w     = 16;
    localparam int byte_w     = 8;
    localparam int region_w   = 8;  // One-hot region vector from the mapper

    // Mapper region indices
    localparam int reg_rom_hi = 2;  // Regions 0 to 2 hold program ROM
    localparam int reg_ram    = 3;  // Work RAM
    localparam int reg_oram   = 4;  // Object RAM
    localparam int reg_vram   = 5;  // Tile and text RAM
    localparam int reg_pal    = 6;  // Palette
    localparam int reg_io     = 7;  // Cabinet I/O and video control

    // Game identifiers that change the glue behavior
    localparam logic [byte_w-1:0] game_passsht      = 8'h02;
    localparam logic [byte_w-1:0] game_5358_large_a = 8'h10;
    localparam logic [byte_w-1:0] game_bullet       = 8'h11;
    localparam logic [byte_w-1:0] game_passsht2     = 8'h13;
    localparam logic [byte_w-1:0] game_passsht3     = 8'h18;
    localparam logic [byte_w-1:0] game_5358_large_b = 8'h1a;

    // Value seen by the CPU when nothing drives the bus
    localparam logic [data_w-1:0] bus_idle = 16'hffff;

endpackage

/* hw/s16b_read_mux.sv */
// CPU read mux: registered priority selection of the data returned to the CPU
`timescale 1ns/1ps

module s16b_read_mux (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rom_cs,
    input  logic                        ram_cs,
    input  logic                        vram_cs,
    input  logic                        char_cs,
    input  logic                        pal_cs,
    input  logic                        objram_cs,
    input  logic                        io_cs,
    input  logic [s16b_pkg::data_w-1:0] ram_data,   // Shared by work RAM and tile RAM
    input  logic [s16b_pkg::data_w-1:0] rom_data,
    input  logic [s16b_pkg::data_w-1:0] char_dout,
    input  logic [s16b_pkg::data_w-1:0] pal_dout,
    input  logic [s16b_pkg::data_w-1:0] obj_dout,
    input  logic [s16b_pkg::byte_w-1:0] cab_dout,
    output logic [s16b_pkg::data_w-1:0] cpu_din
);
    import s16b_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= bus_idle;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {8'hff, cab_dout};   // I/O is byte wide
        end
        // Unmapped cycles keep the last value
    end

endmodule

/* hw/s16b_region_decode.sv */
// Region decode: registers chip selects from the mapper region vector and CPU strobes
`timescale 1ns/1ps

module s16b_region_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          as_n,
    input  logic                          rnw,
    input  logic                          uds_n,
    input  logic                          lds_n,
    input  logic                          addr16,   // Splits text RAM from tile RAM
    input  logic [s16b_pkg::region_w-1:0] active,
    output logic                          rom_cs,
    output logic                          ram_cs,
    output logic                          vram_cs,
    output logic                          char_cs,
    output logic                          pal_cs,
    output logic                          objram_cs,
    output logic                          io_cs,
    output logic                          tbank_cs
);
    import s16b_pkg::*;

    logic ds_act;

    // Either byte lane strobed
    assign ds_act = !(uds_n && lds_n);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (!as_n) begin
            rom_cs    <= (|active[reg_rom_hi:0]) && rnw;    // Program fetch and data reads
            char_cs   <= active[reg_vram] && addr16;
            pal_cs    <= active[reg_pal];
            objram_cs <= active[reg_oram];
            io_cs     <= active[reg_io];
            tbank_cs  <= active[reg_rom_hi] && !rnw;       // Bank latch sits in ROM space
            // RAM selects follow the data strobes so a read-modify-write
            // drops them between its two halves
            vram_cs   <= ds_act && active[reg_vram] && !addr16;
            ram_cs    <= ds_act && active[reg_ram];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end
    end

endmodule

/* hw/s16b_rom_bank.sv */
// ROM banking: maps the CPU word address to a program ROM address per board type
`timescale 1ns/1ps

module s16b_rom_bank (
    input  logic [s16b_pkg::byte_w-1:0]   game_id,
    input  logic [s16b_pkg::addr_w:1]     addr,
    input  logic [2:0]                    active,   // ROM regions only
    output logic [s16b_pkg::rom_addr_w:1] rom_addr
);
    import s16b_pkg::*;

    logic [1:0] act_enc;

    always_comb begin
        case (active)
            3'b001:  act_enc = 2'd0;
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    always_comb begin
        if (game_id[7:4] == 4'd2 || game_id[7:4] == 4'd3) begin
            rom_addr = addr[18:1];                          // 5797 boards, flat map
        end else if (game_id == game_5358_large_a || game_id == game_5358_large_b) begin
            rom_addr = {act_enc, addr[16:1]};
        end else if (game_id[7:3] == 5'd2 || game_id[7:3] == 5'd3) begin
            rom_addr = {1'b0, act_enc, addr[15:1]};         // 5358 small
        end else if (game_id[7:3] == 5'd1) begin
            rom_addr = {1'b0, addr[17:1]};
        end else begin
            // 5521 and 5704 boards, two 256 kB halves
            rom_addr = {act_enc[0], addr[17:1]};
        end
    end

endmodule

/* hw/s16b_video_regs.sv */
// Video registers: flip and video enable in I/O space, tile bank latch in ROM space
`timescale 1ns/1ps

module s16b_video_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        io_cs,
    input  logic                        tbank_cs,
    input  logic                        rnw,
    input  logic                        lds_n,
    input  logic [s16b_pkg::addr_w:1]   addr,
    input  logic [s16b_pkg::data_w-1:0] cpu_dout,
    output logic                        flip,
    output logic                        video_en,
    output logic [5:0]                  tile_bank
);
    logic lo_wr;

    assign lo_wr = !rnw && !lds_n;   // Low byte write

    // Video control lives in I/O group 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b1;       // Screen on out of reset
        end else if (io_cs && addr[13:12] == 2'd0 && lo_wr) begin
            flip     <= cpu_dout[6];
            video_en <= cpu_dout[5];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_cs && lo_wr) begin
            if (addr[1]) begin
                tile_bank[5:3] <= cpu_dout[2:0];   // Second bank pair
            end else begin
                tile_bank[2:0] <= cpu_dout[2:0];
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the s16b_main_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --no-stop-fail \
        -f s16b_main_bus.f --top-module s16b_main_bus_tb; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vs16b_main_bus_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

/* s16b_main_bus.f */
hw/s16b_pkg.sv
hw/s16b_region_decode.sv
hw/s16b_rom_bank.sv
hw/s16b_video_regs.sv
hw/s16b_cab_inputs.sv
hw/s16b_read_mux.sv
hw/s16b_main_bus.sv
bench/s16b_main_bus_chk.sv
bench/s16b_main_bus_tb.sv
